// File: hdl/ber_pkg.sv
package ber_pkg;

    ////////////////////
    // Frame geometry
    ////////////////////
    localparam int CHUNK_W      = 64;
    localparam int SEG_W        = 16;
    localparam int SEG_NUM      = CHUNK_W / SEG_W;
    localparam int CHUNK_NUM    = 6;
    localparam int FRAME_BITS   = CHUNK_W * CHUNK_NUM;

    // count_done hold time for the slower decoder clock
    localparam int DONE_STRETCH = 2;

    typedef logic [CHUNK_W-1:0]                chunk_t;
    typedef logic [$clog2(SEG_W + 1)-1:0]      seg_cnt_t;
    typedef logic [$clog2(CHUNK_W + 1)-1:0]    chunk_cnt_t;
    typedef logic [$clog2(FRAME_BITS + 1)-1:0] frame_err_t;
    typedef logic [31:0]                       stat_cnt_t;

    ////////////////////
    // Register map
    ////////////////////
    typedef logic [2:0]  wb_addr_t;
    typedef logic [31:0] wb_data_t;

    localparam wb_addr_t REG_FRAMES     = 3'd0;
    localparam wb_addr_t REG_ERR_FRAMES = 3'd1;
    localparam wb_addr_t REG_BIT_ERRS   = 3'd2;
    localparam wb_addr_t REG_LAST_ERR   = 3'd3;
    localparam wb_addr_t REG_CTRL       = 3'd4;

    typedef enum logic {
        WB_IDLE,
        WB_ACK
    } wb_state_t;

endpackage

// File: hdl/popcount_seg.sv
`timescale 1ns/1ps

module popcount_seg
    import ber_pkg::*;
(
    input  logic [SEG_W-1:0] seg,
    output seg_cnt_t         count
);

    seg_cnt_t acc;

    // Plain ripple of the set bits, small enough for one cycle
    always_comb begin
        acc = '0;
        for (int i = 0; i < SEG_W; i++) begin
            acc = acc + seg_cnt_t'(seg[i]);
        end
    end

    assign count = acc;

endmodule

// File: hdl/seg_sum_tree.sv
`timescale 1ns/1ps

module seg_sum_tree
    import ber_pkg::*;
(
    input  logic                     eval_clk,
    input  logic                     rstn,
    input  seg_cnt_t [SEG_NUM-1:0]   seg_counts,
    input  logic [1:0]               tag_in,
    output chunk_cnt_t               sum,
    output logic [1:0]               tag_out
);

    chunk_cnt_t [SEG_NUM/2-1:0] pair_q;
    chunk_cnt_t                 sum_q;
    logic [1:0]                 tag_q1;
    logic [1:0]                 tag_q2;

    // Stage 1, neighbouring segments added in pairs
    always_ff @(posedge eval_clk) begin
        for (int i = 0; i < SEG_NUM / 2; i++) begin
            pair_q[i] <= chunk_cnt_t'(seg_counts[2*i]) + chunk_cnt_t'(seg_counts[2*i+1]);
        end
    end

    // Stage 2
    always_ff @(posedge eval_clk) begin
        sum_q <= pair_q[0] + pair_q[1];
    end

    // Tag follows its chunk through both stages
    always_ff @(posedge eval_clk or negedge rstn) begin
        if (!rstn) begin
            tag_q1 <= 2'b00;
            tag_q2 <= 2'b00;
        end else begin
            tag_q1 <= tag_in;
            tag_q2 <= tag_q1;
        end
    end

    assign sum     = sum_q;
    assign tag_out = tag_q2;

endmodule

// File: hdl/errbit_cnt.sv
`timescale 1ns/1ps

module errbit_cnt
    import ber_pkg::*;
(
    input  logic       eval_clk,
    input  logic       rstn,
    input  chunk_t     hard_chunk,
    input  logic       chunk_valid,
    output frame_err_t frame_err,
    output logic       err_frame,
    output logic       result_valid,
    output logic       count_done,
    output logic       busy
);

    typedef logic [$clog2(CHUNK_NUM)-1:0] chunk_idx_t;

    // Tags are {first, last}
    chunk_idx_t             chunk_pos;
    logic                   chunk_first;
    logic                   chunk_last;
    logic                   frame_start;
    chunk_t                 chunk_q;
    logic [1:0]             tag_s1;
    seg_cnt_t [SEG_NUM-1:0] seg_cnt;
    seg_cnt_t [SEG_NUM-1:0] seg_cnt_q;
    logic [1:0]             tag_s2;
    chunk_cnt_t             tree_sum;
    logic [1:0]             tag_s4;
    chunk_cnt_t             zero_cnt_q;
    logic [1:0]             tag_s5;
    frame_err_t             zero_ext;
    frame_err_t             frame_total;
    frame_err_t             acc;
    logic [DONE_STRETCH-1:0] done_sr;
    logic [1:0]             frames_open;

    ////////////////////
    // Input stage
    ////////////////////
    assign chunk_first = (chunk_pos == '0);
    assign chunk_last  = (chunk_pos == chunk_idx_t'(CHUNK_NUM - 1));
    assign frame_start = chunk_valid && chunk_first;

    always_ff @(posedge eval_clk or negedge rstn) begin
        if (!rstn) begin
            chunk_pos <= '0;
        end else if (chunk_valid) begin
            if (chunk_last) begin
                chunk_pos <= '0;
            end else begin
                chunk_pos <= chunk_pos + 1'b1;
            end
        end
    end

    // Idle cycles load all ones, which count as zero errors
    always_ff @(posedge eval_clk) begin
        chunk_q <= chunk_valid ? hard_chunk : '1;
    end

    always_ff @(posedge eval_clk or negedge rstn) begin
        if (!rstn) begin
            tag_s1 <= 2'b00;
        end else begin
            tag_s1 <= chunk_valid ? {chunk_first, chunk_last} : 2'b00;
        end
    end

    ////////////////////
    // Segment counts
    ////////////////////
    for (genvar g = 0; g < SEG_NUM; g++) begin : g_seg
        popcount_seg u_popcount (
            .seg   (chunk_q[g*SEG_W +: SEG_W]),
            .count (seg_cnt[g])
        );
    end

    always_ff @(posedge eval_clk) begin
        seg_cnt_q <= seg_cnt;
    end

    always_ff @(posedge eval_clk or negedge rstn) begin
        if (!rstn) begin
            tag_s2 <= 2'b00;
        end else begin
            tag_s2 <= tag_s1;
        end
    end

    seg_sum_tree u_tree (
        .eval_clk   (eval_clk),
        .rstn       (rstn),
        .seg_counts (seg_cnt_q),
        .tag_in     (tag_s2),
        .sum        (tree_sum),
        .tag_out    (tag_s4)
    );

    ////////////////////
    // Zero count and frame sum
    ////////////////////
    // Under all-zero BPSK a hard 0 is the error bit
    always_ff @(posedge eval_clk) begin
        zero_cnt_q <= chunk_cnt_t'(CHUNK_W) - tree_sum;
    end

    always_ff @(posedge eval_clk or negedge rstn) begin
        if (!rstn) begin
            tag_s5 <= 2'b00;
        end else begin
            tag_s5 <= tag_s4;
        end
    end

    assign zero_ext    = frame_err_t'(zero_cnt_q);
    assign frame_total = tag_s5[1] ? zero_ext : acc + zero_ext;

    always_ff @(posedge eval_clk or negedge rstn) begin
        if (!rstn) begin
            acc       <= '0;
            frame_err <= '0;
            err_frame <= 1'b0;
            done_sr   <= '0;
        end else begin
            acc     <= frame_total;
            done_sr <= {done_sr[DONE_STRETCH-2:0], tag_s5[0]};
            if (tag_s5[0]) begin
                frame_err <= frame_total;
                err_frame <= |frame_total;
            end
        end
    end

    assign result_valid = done_sr[0];
    assign count_done   = |done_sr;

    // Frames between first chunk and result, at most two
    always_ff @(posedge eval_clk or negedge rstn) begin
        if (!rstn) begin
            frames_open <= '0;
        end else if (frame_start && !tag_s5[0]) begin
            frames_open <= frames_open + 1'b1;
        end else if (!frame_start && tag_s5[0]) begin
            frames_open <= frames_open - 1'b1;
        end
    end

    assign busy = |frames_open;

endmodule

// File: hdl/ber_stats.sv
`timescale 1ns/1ps

module ber_stats
    import ber_pkg::*;
(
    input  logic       eval_clk,
    input  logic       rstn,
    input  logic       result_valid,
    input  frame_err_t frame_err,
    input  logic       err_frame,
    input  logic       stats_clear,
    output stat_cnt_t  frames,
    output stat_cnt_t  err_frames,
    output stat_cnt_t  bit_errs,
    output frame_err_t last_err
);

    logic [$bits(stat_cnt_t):0] bit_errs_sum;

    // One extra bit catches the carry for saturation
    assign bit_errs_sum = {1'b0, bit_errs}
                        + {{($bits(stat_cnt_t) + 1 - $bits(frame_err_t)){1'b0}}, frame_err};

    always_ff @(posedge eval_clk or negedge rstn) begin
        if (!rstn) begin
            frames     <= '0;
            err_frames <= '0;
            bit_errs   <= '0;
            last_err   <= '0;
        end else if (stats_clear) begin
            frames     <= '0;
            err_frames <= '0;
            bit_errs   <= '0;
            last_err   <= '0;
        end else if (result_valid) begin
            if (frames != '1) begin
                frames <= frames + 1'b1;
            end
            if (err_frame && err_frames != '1) begin
                err_frames <= err_frames + 1'b1;
            end
            if (bit_errs_sum[$bits(stat_cnt_t)]) begin
                bit_errs <= '1;
            end else begin
                bit_errs <= bit_errs_sum[$bits(stat_cnt_t)-1:0];
            end
            last_err <= frame_err;
        end
    end

endmodule

// File: hdl/ber_wb_regs.sv
`timescale 1ns/1ps

module ber_wb_regs
    import ber_pkg::*;
(
    input  logic       eval_clk,
    input  logic       rstn,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  wb_addr_t   wb_adr,
    input  wb_data_t   wb_dat_w,
    output wb_data_t   wb_dat_r,
    output logic       wb_ack,
    input  stat_cnt_t  frames,
    input  stat_cnt_t  err_frames,
    input  stat_cnt_t  bit_errs,
    input  frame_err_t last_err,
    output logic       stats_clear
);

    wb_state_t state;
    logic      wb_req;
    logic      take_req;
    wb_data_t  rd_data;

    assign wb_req   = wb_cyc && wb_stb;
    assign take_req = (state == WB_IDLE) && wb_req;

    ////////////////////
    // Handshake FSM
    ////////////////////
    // Always back to idle after ack, so ack never repeats
    always_ff @(posedge eval_clk or negedge rstn) begin
        if (!rstn) begin
            state <= WB_IDLE;
        end else begin
            case (state)
                WB_IDLE: begin
                    if (wb_req) begin
                        state <= WB_ACK;
                    end
                end
                WB_ACK: begin
                    state <= WB_IDLE;
                end
                default: begin
                    state <= WB_IDLE;
                end
            endcase
        end
    end

    assign wb_ack = (state == WB_ACK);

    ////////////////////
    // Address decode
    ////////////////////
    always_comb begin
        case (wb_adr)
            REG_FRAMES:     rd_data = frames;
            REG_ERR_FRAMES: rd_data = err_frames;
            REG_BIT_ERRS:   rd_data = bit_errs;
            REG_LAST_ERR:   rd_data = wb_data_t'(last_err);
            default:        rd_data = '0;
        endcase
    end

    // Loaded on entry to WB_ACK, so both are valid in the ack cycle
    always_ff @(posedge eval_clk or negedge rstn) begin
        if (!rstn) begin
            wb_dat_r    <= '0;
            stats_clear <= 1'b0;
        end else begin
            stats_clear <= take_req && wb_we && (wb_adr == REG_CTRL) && wb_dat_w[0];
            if (take_req && !wb_we) begin
                wb_dat_r <= rd_data;
            end
        end
    end

endmodule

// File: hdl/ber_eval_top.sv
`timescale 1ns/1ps

module ber_eval_top
    import ber_pkg::*;
(
    input  logic       eval_clk,
    input  logic       rstn,
    input  chunk_t     hard_chunk,
    input  logic       chunk_valid,
    output frame_err_t frame_err,
    output logic       err_frame,
    output logic       count_done,
    output logic       busy,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  wb_addr_t   wb_adr,
    input  wb_data_t   wb_dat_w,
    output wb_data_t   wb_dat_r,
    output logic       wb_ack
);

    logic       result_valid;
    logic       stats_clear;
    stat_cnt_t  frames;
    stat_cnt_t  err_frames;
    stat_cnt_t  bit_errs;
    frame_err_t last_err;

    errbit_cnt u_errbit_cnt (
        .eval_clk     (eval_clk),
        .rstn         (rstn),
        .hard_chunk   (hard_chunk),
        .chunk_valid  (chunk_valid),
        .frame_err    (frame_err),
        .err_frame    (err_frame),
        .result_valid (result_valid),
        .count_done   (count_done),
        .busy         (busy)
    );

    ber_stats u_stats (
        .eval_clk     (eval_clk),
        .rstn         (rstn),
        .result_valid (result_valid),
        .frame_err    (frame_err),
        .err_frame    (err_frame),
        .stats_clear  (stats_clear),
        .frames       (frames),
        .err_frames   (err_frames),
        .bit_errs     (bit_errs),
        .last_err     (last_err)
    );

    ber_wb_regs u_wb_regs (
        .eval_clk    (eval_clk),
        .rstn        (rstn),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .frames      (frames),
        .err_frames  (err_frames),
        .bit_errs    (bit_errs),
        .last_err    (last_err),
        .stats_clear (stats_clear)
    );

endmodule

// File: test/ber_eval_tb.sv
`timescale 1ns/1ps

module ber_eval_tb
    import ber_pkg::*;
();

    localparam int TIMEOUT     = 50;
    localparam int RESULT_LAT  = 6;
    localparam int RAND_FRAMES = 8;

    logic       eval_clk;
    logic       rstn;
    chunk_t     hard_chunk;
    logic       chunk_valid;
    frame_err_t frame_err;
    logic       err_frame;
    logic       count_done;
    logic       busy;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    wb_addr_t   wb_adr;
    wb_data_t   wb_dat_w;
    wb_data_t   wb_dat_r;
    logic       wb_ack;

    integer     seed;
    int         err_cnt;
    int         timeout_cnt;
    stat_cnt_t  model_frames;
    stat_cnt_t  model_err_frames;
    stat_cnt_t  model_bit_errs;
    stat_cnt_t  model_last_err;

    ber_eval_top u_dut (
        .eval_clk    (eval_clk),
        .rstn        (rstn),
        .hard_chunk  (hard_chunk),
        .chunk_valid (chunk_valid),
        .frame_err   (frame_err),
        .err_frame   (err_frame),
        .count_done  (count_done),
        .busy        (busy),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack)
    );

    always #2 eval_clk = ~eval_clk;

    ////////////////////
    // Helpers
    ////////////////////
    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("ERR at %0t: %s (got %0d, expected %0d)", $time, msg, actual, expected);
            err_cnt++;
        end
    endtask

    // Hard 0 is a bit error under the all-zero codeword
    function automatic int zero_bits(input logic [FRAME_BITS-1:0] frame);
        int n;
        n = 0;
        for (int i = 0; i < FRAME_BITS; i++) begin
            if (frame[i] == 1'b0) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic update_model(input int n);
        model_frames = model_frames + 1;
        if (n != 0) begin
            model_err_frames = model_err_frames + 1;
        end
        model_bit_errs = model_bit_errs + n;
        model_last_err = n;
    endtask

    task automatic send_frame(input logic [FRAME_BITS-1:0] frame);
        for (int c = 0; c < CHUNK_NUM; c++) begin
            hard_chunk  = frame[c*CHUNK_W +: CHUNK_W];
            chunk_valid = 1'b1;
            @(posedge eval_clk);
            #1;
        end
        chunk_valid = 1'b0;
        hard_chunk  = '0;
    endtask

    // Latency counts cycles from the last chunk on the bus, high_cycles the done stretch
    task automatic wait_done(output int latency, output int high_cycles,
                             output frame_err_t err, output logic flag);
        // send_frame has already passed the edge that takes the last chunk
        latency     = 1;
        high_cycles = 0;
        err         = '0;
        flag        = 1'b0;
        do begin
            @(posedge eval_clk);
            #1;
            latency++;
        end while (!count_done && latency < TIMEOUT);
        if (!count_done) begin
            $display("Timeout: count_done did not rise within %0d cycles", TIMEOUT);
            timeout_cnt++;
            return;
        end
        err  = frame_err;
        flag = err_frame;
        while (count_done && high_cycles < TIMEOUT) begin
            high_cycles++;
            @(posedge eval_clk);
            #1;
        end
    endtask

    task automatic wb_transfer(input logic we, input wb_addr_t addr, input wb_data_t wdata,
                               output wb_data_t rdata);
        int cycles;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = addr;
        wb_dat_w = wdata;
        cycles   = 0;
        do begin
            @(posedge eval_clk);
            #1;
            cycles++;
        end while (!wb_ack && cycles < TIMEOUT);
        if (!wb_ack) begin
            $display("Timeout: no Wishbone ack for address %0d", addr);
            timeout_cnt++;
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
        wb_transfer(1'b0, addr, '0, data);
    endtask

    task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
        wb_data_t unused;
        wb_transfer(1'b1, addr, data, unused);
    endtask

    task automatic check_stats(input string tag);
        wb_data_t val;
        wb_read(REG_FRAMES, val);
        check(val, model_frames, {tag, ": frames"});
        wb_read(REG_ERR_FRAMES, val);
        check(val, model_err_frames, {tag, ": error frames"});
        wb_read(REG_BIT_ERRS, val);
        check(val, model_bit_errs, {tag, ": bit errors"});
        wb_read(REG_LAST_ERR, val);
        check(val, model_last_err, {tag, ": last error count"});
    endtask

    task automatic run_single(input logic [FRAME_BITS-1:0] frame, input int exp_err,
                              input string name);
        int         latency;
        int         high_cycles;
        frame_err_t err;
        logic       flag;
        send_frame(frame);
        check(busy, 1'b1, {name, ": busy in flight"});
        wait_done(latency, high_cycles, err, flag);
        check(latency, RESULT_LAT, {name, ": result latency"});
        check(err, exp_err, {name, ": frame_err"});
        check(flag, exp_err != 0, {name, ": err_frame"});
        check(high_cycles, DONE_STRETCH, {name, ": count_done width"});
        check(busy, 1'b0, {name, ": busy after result"});
        update_model(exp_err);
    endtask

    ////////////////////
    // Tests
    ////////////////////
    task automatic test_reset();
        check(busy, 1'b0, "reset: busy");
        check(count_done, 1'b0, "reset: count_done");
        check(err_frame, 1'b0, "reset: err_frame");
        check_stats("reset");
    endtask

    task automatic test_fixed_frames();
        run_single('1, 0, "all ones");
        run_single('0, FRAME_BITS, "all zeros");
    endtask

    // Single bits at chunk and segment edges, plus one full segment
    task automatic test_boundaries();
        logic [FRAME_BITS-1:0] frame;
        int                    idx [16];
        idx   = '{0, 15, 16, 31, 32, 63, 64, 127, 128, 191, 192, 255, 256, 319, 320, 383};
        frame = '1;
        foreach (idx[i]) begin
            frame[idx[i]] = 1'b0;
        end
        frame[208 +: SEG_W] = '0;
        run_single(frame, 32, "boundary bits");
    endtask

    task automatic test_back_to_back();
        logic [FRAME_BITS-1:0] frames_q [RAND_FRAMES];
        int                    exp_q [RAND_FRAMES];
        for (int f = 0; f < RAND_FRAMES; f++) begin
            for (int w = 0; w < FRAME_BITS / 32; w++) begin
                frames_q[f][w*32 +: 32] = $random(seed);
                // Odd frames carry fewer errors
                if (f % 2 == 1) begin
                    frames_q[f][w*32 +: 32] = frames_q[f][w*32 +: 32] | $random(seed);
                end
            end
        end
        frames_q[5] = '1;
        for (int f = 0; f < RAND_FRAMES; f++) begin
            exp_q[f] = zero_bits(frames_q[f]);
        end
        fork
            begin
                for (int f = 0; f < RAND_FRAMES; f++) begin
                    send_frame(frames_q[f]);
                end
            end
            begin
                int         latency;
                int         high_cycles;
                frame_err_t err;
                logic       flag;
                for (int f = 0; f < RAND_FRAMES; f++) begin
                    wait_done(latency, high_cycles, err, flag);
                    check(err, exp_q[f], $sformatf("random frame %0d: frame_err", f));
                    check(flag, exp_q[f] != 0, $sformatf("random frame %0d: err_frame", f));
                    check(high_cycles, DONE_STRETCH,
                          $sformatf("random frame %0d: count_done width", f));
                    update_model(exp_q[f]);
                end
            end
        join
    endtask

    task automatic test_registers();
        wb_data_t val;
        check_stats("after random frames");
        wb_read(3'd6, val);
        check(val, 32'd0, "unused address 6");
    endtask

    task automatic test_clear();
        logic [FRAME_BITS-1:0] frame;
        wb_write(REG_CTRL, 32'd1);
        model_frames     = '0;
        model_err_frames = '0;
        model_bit_errs   = '0;
        model_last_err   = '0;
        check_stats("after clear");
        frame        = '1;
        frame[70 +: 5] = '0;
        run_single(frame, 5, "frame after clear");
        check_stats("first frame after clear");
    endtask

    initial begin
        eval_clk         = 1'b0;
        rstn             = 1'b0;
        hard_chunk       = '0;
        chunk_valid      = 1'b0;
        wb_cyc           = 1'b0;
        wb_stb           = 1'b0;
        wb_we            = 1'b0;
        wb_adr           = '0;
        wb_dat_w         = '0;
        seed             = 32'hf9a5_efb0;
        err_cnt          = 0;
        timeout_cnt      = 0;
        model_frames     = '0;
        model_err_frames = '0;
        model_bit_errs   = '0;
        model_last_err   = '0;
        repeat (2) @(posedge eval_clk);
        #1;
        rstn = 1'b1;

        test_reset();
        test_fixed_frames();
        test_boundaries();
        test_back_to_back();
        test_registers();
        test_clear();

        $display("Summary: %0d check errors, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: sim.f
hdl/ber_pkg.sv
hdl/popcount_seg.sv
hdl/seg_sum_tree.sv
hdl/errbit_cnt.sv
hdl/ber_stats.sv
hdl/ber_wb_regs.sv
hdl/ber_eval_top.sv
test/ber_eval_tb.sv

// File: Bender.yml
package:
  name: ber_eval

sources:
  - hdl/ber_pkg.sv
  - hdl/popcount_seg.sv
  - hdl/seg_sum_tree.sv
  - hdl/errbit_cnt.sv
  - hdl/ber_stats.sv
  - hdl/ber_wb_regs.sv
  - hdl/ber_eval_top.sv
  - target: test
    files:
      - test/ber_eval_tb.sv
